// File: rtl/arbitor.sv
module arbitor
	import raypipe_geom_pkg::*;
(
	input logic clk,
	input logic reset,

	// two requesters
	input logic [1:0] valid_us,
	input trav_req_t [1:0] data_us,
	output logic [1:0] stall_us,

	// fork towards cache and ray store
	input logic cache_stall,
	input logic rs_stall,
	output logic fork_valid,
	output trav_req_t fork_data
);

	logic rr_ptr;
	logic sel;
	logic ds_ready;

	// favour the pointer, fall back to the other port
	assign sel = valid_us[rr_ptr] ? rr_ptr : ~rr_ptr;

	// both sides must be free, otherwise the fork would split
	assign ds_ready = !cache_stall && !rs_stall;

	// valid only offered when both consumers take it in the same cycle
	assign fork_valid = (|valid_us) && ds_ready;
	assign fork_data = data_us[sel];

	always_comb begin
		stall_us = 2'b11;
		if (fork_valid) begin
			stall_us[sel] = 1'b0;
		end
	end

	// pointer moves past the granted port on every transfer
	always_ff @(posedge clk) begin
		if (reset) begin
			rr_ptr <= 1'b0;
		end else if (fork_valid) begin
			rr_ptr <= ~sel;
		end
	end

endmodule

// File: rtl/cache_and_miss_handler.sv
module cache_and_miss_handler
	import raypipe_geom_pkg::*;
	import raypipe_mem_pkg::*;
(
	input logic clk,
	input logic reset,

	// request side
	input logic us_valid,
	input trav_req_t us_data,
	output logic us_stall,

	// node to traversal
	output logic ds_valid,
	output node_data_t ds_data,
	input logic ds_stall,

	// memory port
	output logic [MEM_ADDR_W-1:0] addr_cache_to_sdram,
	output logic [TRANS_W-1:0] transSize,
	output logic readReq,
	input logic readValid_out,
	input logic [31:0] readData,
	input logic doneRead
);

	cache_state_t state;

	logic [C_TAG_W-1:0] tag_mem [C_NUM_LINES];
	aabb_t line_mem [C_NUM_LINES];
	logic [C_NUM_LINES-1:0] line_valid;

	logic [C_INDEX_W-1:0] us_index;
	logic [C_TAG_W-1:0] us_tag;
	logic [C_INDEX_W-1:0] miss_index;
	trav_req_t miss_req;
	aabb_t fill_box;
	logic [$clog2(WORDS_PER_NODE)-1:0] word_cnt;
	logic us_take;
	logic us_hit;
	logic ds_take;
	logic fill_done;
	logic word_in;

	assign us_index = us_data.nodeID[C_INDEX_W-1:0];
	assign us_tag = us_data.nodeID[C_INDEX_W +: C_TAG_W];
	assign miss_index = miss_req.nodeID[C_INDEX_W-1:0];
	assign us_hit = line_valid[us_index] && (tag_mem[us_index] == us_tag);

	assign ds_take = ds_valid && !ds_stall;
	// blocking: nothing new while a miss is open or the output is held
	assign us_stall = (state != C_IDLE) || (ds_valid && ds_stall);
	assign us_take = us_valid && !us_stall;

	assign fill_done = (state == C_FILL) && doneRead;
	assign word_in = readValid_out && ((state == C_REQ) || (state == C_FILL));

	// request held until the first word shows up
	assign readReq = (state == C_REQ);
	assign addr_cache_to_sdram = MEM_ADDR_W'(miss_req.nodeID) * MEM_ADDR_W'(WORDS_PER_NODE);
	assign transSize = TRANS_W'(WORDS_PER_NODE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= C_IDLE;
			line_valid <= '0;
			ds_valid <= 1'b0;
			word_cnt <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (us_take && !us_hit) begin
						state <= C_REQ;
					end
				end
				C_REQ: begin
					if (readValid_out) begin
						state <= C_FILL;
					end
				end
				C_FILL: begin
					if (doneRead) begin
						state <= C_DONE;
						line_valid[miss_index] <= 1'b1;
					end
				end
				default: begin
					// wait until the refilled node is taken
					if (ds_take) begin
						state <= C_IDLE;
					end
				end
			endcase

			if ((us_take && us_hit) || fill_done) begin
				ds_valid <= 1'b1;
			end else if (ds_take) begin
				ds_valid <= 1'b0;
			end

			if (state == C_IDLE) begin
				word_cnt <= '0;
			end else if (word_in) begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (us_take && !us_hit) begin
			miss_req <= us_data;
		end

		if (us_take && us_hit) begin
			ds_data <= '{req: us_data, box: line_mem[us_index]};
		end else if (fill_done) begin
			ds_data <= '{req: miss_req, box: fill_box};
		end

		if (fill_done) begin
			tag_mem[miss_index] <= miss_req.nodeID[C_INDEX_W +: C_TAG_W];
			line_mem[miss_index] <= fill_box;
		end

		// unpack memory words into the box
		if (word_in) begin
			case (word_cnt)
				2'd0: begin
					fill_box.min.y <= readData[31:16];
					fill_box.min.x <= readData[15:0];
				end
				2'd1: begin
					fill_box.max.x <= readData[31:16];
					fill_box.min.z <= readData[15:0];
				end
				default: begin
					fill_box.max.z <= readData[31:16];
					fill_box.max.y <= readData[15:0];
				end
			endcase
		end
	end

endmodule

// File: rtl/raypipe.sv
module raypipe
	import raypipe_geom_pkg::*;
	import raypipe_mem_pkg::*;
(
	input logic clk,
	input logic reset,

	// request sources
	input logic req_valid0,
	input trav_req_t req_data0,
	output logic req_stall0,
	input logic req_valid1,
	input trav_req_t req_data1,
	output logic req_stall1,

	// ray store writes
	input logic raystore_we,
	input rayID_t raystore_write_addr,
	input ray_vec_t raystore_write_data,

	// node memory
	output logic [MEM_ADDR_W-1:0] addr_cache_to_sdram,
	output logic [TRANS_W-1:0] transSize,
	output logic readReq,
	input logic readValid_out,
	input logic [31:0] readData,
	input logic doneRead,

	output logic result_valid,
	output trav_result_t result_data
);

	// arbitor fork
	logic fork_valid;
	trav_req_t fork_data;
	logic cache_stall;
	logic rs_stall;

	// cache to traversal
	logic node_valid;
	node_data_t node_data;
	logic node_stall;

	// raystore to traversal
	logic ray_valid;
	ray_data_t ray_data;
	logic ray_stall;

	arbitor arbitor_inst (
		.clk, .reset,
		.valid_us({req_valid1, req_valid0}),
		.data_us({req_data1, req_data0}),
		.stall_us({req_stall1, req_stall0}),
		.cache_stall, .rs_stall,
		.fork_valid, .fork_data
	);

	cache_and_miss_handler node_cache (
		.clk, .reset,
		.us_valid(fork_valid), .us_data(fork_data), .us_stall(cache_stall),
		.ds_valid(node_valid), .ds_data(node_data), .ds_stall(node_stall),
		.addr_cache_to_sdram, .transSize, .readReq,
		.readValid_out, .readData, .doneRead
	);

	raystore raystore_inst (
		.clk, .reset,
		.raystore_we, .raystore_write_addr, .raystore_write_data,
		.rd_valid(fork_valid), .rd_data(fork_data), .rd_stall(rs_stall),
		.ray_valid, .ray_data, .ray_stall
	);

	trav_unit trav_unit_inst (
		.clk, .reset,
		.node_valid, .node_data, .node_stall,
		.ray_valid, .ray_data, .ray_stall,
		.result_valid, .result_data
	);

endmodule

// File: rtl/raypipe_geom_pkg.sv
package raypipe_geom_pkg;

	// ray store and traversal constants
	localparam int NUM_RAYS = 16;
	localparam int INV_FRAC_W = 8;
	localparam int RS_QUEUE_DEPTH = 4;

	typedef logic signed [15:0] coord_t;
	typedef logic signed [31:0] dist_t;
	typedef logic [3:0] rayID_t;
	typedef logic [7:0] nodeID_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vector_t;

	typedef struct packed {
		vector_t min;
		vector_t max;
	} aabb_t;

	// inv_dir carries INV_FRAC_W fraction bits
	typedef struct packed {
		vector_t origin;
		vector_t inv_dir;
		dist_t t_max;
	} ray_vec_t;

	typedef struct packed {
		rayID_t rayID;
		nodeID_t nodeID;
	} trav_req_t;

	// cache to traversal
	typedef struct packed {
		trav_req_t req;
		aabb_t box;
	} node_data_t;

	// ray store to traversal
	typedef struct packed {
		rayID_t rayID;
		ray_vec_t ray;
	} ray_data_t;

	typedef struct packed {
		rayID_t rayID;
		nodeID_t nodeID;
		logic hit;
		dist_t t_near;
	} trav_result_t;

endpackage

// File: rtl/raypipe_mem_pkg.sv
package raypipe_mem_pkg;

	// node cache geometry, index taken from the low node bits
	localparam int C_INDEX_W = 4;
	localparam int C_TAG_W = 4;
	localparam int C_NUM_LINES = 16;

	// one node is three 32 bit words in memory
	localparam int WORDS_PER_NODE = 3;

	// external memory port
	localparam int MEM_ADDR_W = 25;
	localparam int TRANS_W = 2;

	// miss handler states
	typedef enum logic [1:0] {
		C_IDLE,
		C_REQ,
		C_FILL,
		C_DONE
	} cache_state_t;

endpackage

// File: rtl/raystore.sv
module raystore
	import raypipe_geom_pkg::*;
(
	input logic clk,
	input logic reset,

	// external write port
	input logic raystore_we,
	input rayID_t raystore_write_addr,
	input ray_vec_t raystore_write_data,

	// read requests from the arbitor
	input logic rd_valid,
	input trav_req_t rd_data,
	output logic rd_stall,

	// rays to traversal
	output logic ray_valid,
	output ray_data_t ray_data,
	input logic ray_stall
);

	ray_vec_t ray_mem [NUM_RAYS];
	ray_data_t queue [RS_QUEUE_DEPTH];

	logic [$clog2(RS_QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(RS_QUEUE_DEPTH)-1:0] rd_ptr;
	logic [$clog2(RS_QUEUE_DEPTH+1)-1:0] count;
	logic push;
	logic pop;
	ray_vec_t rd_ray;

	function automatic logic [$clog2(RS_QUEUE_DEPTH)-1:0] next_ptr(
		input logic [$clog2(RS_QUEUE_DEPTH)-1:0] ptr
	);
		if (ptr == $bits(ptr)'(RS_QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign rd_stall = (count == $bits(count)'(RS_QUEUE_DEPTH));
	assign push = rd_valid && !rd_stall;
	assign ray_valid = (count != '0);
	assign pop = ray_valid && !ray_stall;
	assign ray_data = queue[rd_ptr];

	// same-cycle write to the entry being read wins
	assign rd_ray = (raystore_we && (raystore_write_addr == rd_data.rayID)) ?
		raystore_write_data : ray_mem[rd_data.rayID];

	always_ff @(posedge clk) begin
		if (raystore_we) begin
			ray_mem[raystore_write_addr] <= raystore_write_data;
		end
		if (push) begin
			queue[wr_ptr] <= '{rayID: rd_data.rayID, ray: rd_ray};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: rtl/trav_unit.sv
module trav_unit
	import raypipe_geom_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic node_valid,
	input node_data_t node_data,
	output logic node_stall,

	input logic ray_valid,
	input ray_data_t ray_data,
	output logic ray_stall,

	// no back-pressure on the result
	output logic result_valid,
	output trav_result_t result_data
);

	logic join_ok;
	dist_t t_lo [3];
	dist_t t_hi [3];
	dist_t t_near;
	dist_t t_far;
	logic hit;

	// distance to one slab plane, fixed point product scaled back
	function automatic dist_t plane_dist(input coord_t bound, input coord_t org,
		input coord_t inv);
		logic signed [16:0] diff;
		logic signed [32:0] prod;
		diff = bound - org;
		prod = diff * inv;
		return dist_t'(prod >>> INV_FRAC_W);
	endfunction

	// pop both sides together
	assign join_ok = node_valid && ray_valid;
	assign node_stall = !join_ok;
	assign ray_stall = !join_ok;

	always_comb begin
		dist_t d0 [3];
		dist_t d1 [3];
		d0[0] = plane_dist(node_data.box.min.x, ray_data.ray.origin.x, ray_data.ray.inv_dir.x);
		d1[0] = plane_dist(node_data.box.max.x, ray_data.ray.origin.x, ray_data.ray.inv_dir.x);
		d0[1] = plane_dist(node_data.box.min.y, ray_data.ray.origin.y, ray_data.ray.inv_dir.y);
		d1[1] = plane_dist(node_data.box.max.y, ray_data.ray.origin.y, ray_data.ray.inv_dir.y);
		d0[2] = plane_dist(node_data.box.min.z, ray_data.ray.origin.z, ray_data.ray.inv_dir.z);
		d1[2] = plane_dist(node_data.box.max.z, ray_data.ray.origin.z, ray_data.ray.inv_dir.z);
		// negative inv_dir swaps entry and exit
		for (int a = 0; a < 3; a++) begin
			t_lo[a] = (d0[a] < d1[a]) ? d0[a] : d1[a];
			t_hi[a] = (d0[a] < d1[a]) ? d1[a] : d0[a];
		end
		t_near = t_lo[0];
		t_far = t_hi[0];
		for (int a = 1; a < 3; a++) begin
			if (t_lo[a] > t_near) begin
				t_near = t_lo[a];
			end
			if (t_hi[a] < t_far) begin
				t_far = t_hi[a];
			end
		end
		hit = (t_near <= t_far) && (t_far >= 0) && (t_near <= ray_data.ray.t_max);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= join_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (join_ok) begin
			result_data <= '{rayID: node_data.req.rayID, nodeID: node_data.req.nodeID,
				hit: hit, t_near: t_near};
		end
	end

endmodule

// File: run_sim.sh
#!/bin/bash
# build with Verilator and run, pass only if the log holds the pass line

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module raypipe_tb \
	-o raypipe_sim && ./obj_dir/raypipe_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/raypipe_checker.sv
module raypipe_checker
	import raypipe_geom_pkg::*;
	import raypipe_mem_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid0,
	input trav_req_t req_data0,
	input logic req_stall0,
	input logic req_valid1,
	input trav_req_t req_data1,
	input logic req_stall1,
	input logic raystore_we,
	input rayID_t raystore_write_addr,
	input ray_vec_t raystore_write_data,
	input logic [MEM_ADDR_W-1:0] addr_cache_to_sdram,
	input logic [TRANS_W-1:0] transSize,
	input logic readReq,
	input logic result_valid,
	input trav_result_t result_data,
	input logic [31:0] node_mem [256*WORDS_PER_NODE],
	output int err_cnt,
	output int check_cnt,
	output int pending
);

	typedef struct packed {
		rayID_t rayID;
		nodeID_t nodeID;
		logic hit;
		dist_t t_near;
		logic miss;
		int miss_no;
		int cycle;
	} expect_t;

	expect_t exp_q [$];
	ray_vec_t ray_copy [NUM_RAYS];
	logic [C_NUM_LINES-1:0] line_ok;
	logic [C_TAG_W-1:0] line_tag [C_NUM_LINES];
	logic last_port;
	logic req_prev;
	nodeID_t miss_node;
	int miss_total;
	int reads_seen;
	int cycle;

	initial begin
		err_cnt = 0;
		check_cnt = 0;
		pending = 0;
	end

	task automatic problem(input string what);
		err_cnt++;
		$display("%0t: %s", $time, what);
	endtask

	task automatic compare(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		check_cnt++;
		if (exp_v !== act_v) begin
			err_cnt++;
			$display("ERR %s expected %0h actual %0h", name, exp_v, act_v);
		end
	endtask

	// one slab plane in 8 fraction bit fixed point
	function automatic int plane(input coord_t bound, input coord_t org, input coord_t inv);
		longint prod;
		prod = (longint'(bound) - longint'(org)) * longint'(inv);
		return int'(prod >>> INV_FRAC_W);
	endfunction

	function automatic aabb_t node_box(input nodeID_t id);
		int base;
		aabb_t b;
		base = int'(id) * WORDS_PER_NODE;
		b.min.x = node_mem[base][15:0];
		b.min.y = node_mem[base][31:16];
		b.min.z = node_mem[base+1][15:0];
		b.max.x = node_mem[base+1][31:16];
		b.max.y = node_mem[base+2][15:0];
		b.max.z = node_mem[base+2][31:16];
		return b;
	endfunction

	task automatic slab_model(input aabb_t box, input ray_vec_t ray, output logic hit,
		output dist_t near);
		coord_t bmin [3];
		coord_t bmax [3];
		coord_t org [3];
		coord_t inv [3];
		int d0;
		int d1;
		int far_v;
		bmin = '{box.min.x, box.min.y, box.min.z};
		bmax = '{box.max.x, box.max.y, box.max.z};
		org = '{ray.origin.x, ray.origin.y, ray.origin.z};
		inv = '{ray.inv_dir.x, ray.inv_dir.y, ray.inv_dir.z};
		near = -32'sd2147483647;
		far_v = 32'sd2147483647;
		for (int a = 0; a < 3; a++) begin
			d0 = plane(bmin[a], org[a], inv[a]);
			d1 = plane(bmax[a], org[a], inv[a]);
			// entry is the nearer plane whatever the direction sign
			if ((d0 < d1 ? d0 : d1) > near) begin
				near = (d0 < d1) ? d0 : d1;
			end
			if ((d0 < d1 ? d1 : d0) < far_v) begin
				far_v = (d0 < d1) ? d1 : d0;
			end
		end
		hit = (near <= far_v) && (far_v >= 0) && (near <= ray.t_max);
	endtask

	task automatic check_result();
		expect_t e;
		if (result_valid) begin
			if (exp_q.size() == 0) begin
				problem("result arrived with no request outstanding");
			end else begin
				e = exp_q.pop_front();
				compare("result_ray", e.rayID, result_data.rayID);
				compare("result_node", e.nodeID, result_data.nodeID);
				compare("slab_hit", e.hit, result_data.hit);
				compare("slab_t_near", e.t_near, result_data.t_near);
				if (!e.miss) begin
					compare("hit_latency", 2, cycle - e.cycle);
				end else if (reads_seen < e.miss_no) begin
					problem("missed node returned without a memory read");
				end
			end
		end
	endtask

	task automatic check_memory();
		if (readReq && !req_prev) begin
			reads_seen++;
			if (reads_seen > miss_total) begin
				problem("memory read issued for a node that should hit");
			end else begin
				compare("miss_addr", int'(miss_node) * WORDS_PER_NODE, addr_cache_to_sdram);
				compare("miss_size", WORDS_PER_NODE, transSize);
			end
		end
		req_prev = readReq;
	endtask

	task automatic take_requests();
		logic t0;
		logic t1;
		trav_req_t req;
		ray_vec_t ray;
		expect_t e;
		logic [C_INDEX_W-1:0] idx;
		t0 = req_valid0 && !req_stall0;
		t1 = req_valid1 && !req_stall1;
		if (t0 && t1) begin
			problem("both request ports granted in the same cycle");
		end else if (t0 || t1) begin
			req = t1 ? req_data1 : req_data0;
			if (req_valid0 && req_valid1) begin
				compare("arb_port", !last_port, t1);
			end
			last_port = t1;
			// a same cycle write reaches the read
			ray = (raystore_we && (raystore_write_addr == req.rayID)) ?
				raystore_write_data : ray_copy[req.rayID];
			idx = req.nodeID[C_INDEX_W-1:0];
			e.rayID = req.rayID;
			e.nodeID = req.nodeID;
			e.miss = !(line_ok[idx] && (line_tag[idx] == req.nodeID[C_INDEX_W +: C_TAG_W]));
			if (e.miss) begin
				miss_total++;
				miss_node = req.nodeID;
				line_ok[idx] = 1'b1;
				line_tag[idx] = req.nodeID[C_INDEX_W +: C_TAG_W];
			end
			e.miss_no = miss_total;
			e.cycle = cycle;
			slab_model(node_box(req.nodeID), ray, e.hit, e.t_near);
			exp_q.push_back(e);
		end
	endtask

	// sampled mid cycle, everything settled
	always @(negedge clk) begin
		if (reset) begin
			if (readReq !== 1'b0) begin
				problem("readReq high during reset");
			end
			if (result_valid !== 1'b0) begin
				problem("result_valid high during reset");
			end
			exp_q.delete();
			line_ok = '0;
			last_port = 1'b1;
			req_prev = 1'b0;
			miss_total = 0;
			reads_seen = 0;
			cycle = 0;
		end else begin
			cycle++;
			check_result();
			check_memory();
			take_requests();
			if (raystore_we) begin
				ray_copy[raystore_write_addr] = raystore_write_data;
			end
		end
		pending = exp_q.size();
	end

endmodule

// File: verification/raypipe_properties.sv
module raypipe_properties
	import raypipe_geom_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid0,
	input trav_req_t req_data0,
	input logic req_stall0,
	input logic req_valid1,
	input trav_req_t req_data1,
	input logic req_stall1,
	input logic node_valid,
	input node_data_t node_data,
	input logic node_stall,
	input logic ray_valid,
	input ray_data_t ray_data,
	input logic ray_stall,
	input logic readReq,
	input logic readValid_out,
	input logic doneRead
);

	int fail_cnt = 0;
	logic [1:0] word_cnt;

	// words returned since the last doneRead
	always_ff @(posedge clk) begin
		if (reset || doneRead) begin
			word_cnt <= '0;
		end else if (readValid_out) begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	req0_hold: assert property (@(posedge clk) disable iff (reset)
		req_valid0 && req_stall0 |=> req_valid0 && $stable(req_data0))
		else begin
			$error("request port 0 changed while stalled");
			fail_cnt++;
		end

	req1_hold: assert property (@(posedge clk) disable iff (reset)
		req_valid1 && req_stall1 |=> req_valid1 && $stable(req_data1))
		else begin
			$error("request port 1 changed while stalled");
			fail_cnt++;
		end

	node_hold: assert property (@(posedge clk) disable iff (reset)
		node_valid && node_stall |=> node_valid && $stable(node_data))
		else begin
			$error("node output changed while stalled");
			fail_cnt++;
		end

	ray_hold: assert property (@(posedge clk) disable iff (reset)
		ray_valid && ray_stall |=> ray_valid && $stable(ray_data))
		else begin
			$error("ray output changed while stalled");
			fail_cnt++;
		end

	read_req_hold: assert property (@(posedge clk) disable iff (reset)
		readReq && !readValid_out |=> readReq)
		else begin
			$error("readReq dropped before the first word");
			fail_cnt++;
		end

	three_words: assert property (@(posedge clk) disable iff (reset)
		doneRead |-> (word_cnt == 2'd3) && !readValid_out)
		else begin
			$error("doneRead without exactly three words");
			fail_cnt++;
		end

endmodule

// File: verification/raypipe_tb.sv
module raypipe_tb
	import raypipe_geom_pkg::*;
	import raypipe_mem_pkg::*;
();

	localparam int DRIVE_DLY = 2;
	localparam int NODE_WORDS = 256 * WORDS_PER_NODE;
	localparam int TRAFFIC_CYCLES = 1500;
	localparam int DRAIN_TIMEOUT = 2000;

	logic clk;
	logic reset;
	logic req_valid0;
	trav_req_t req_data0;
	logic req_stall0;
	logic req_valid1;
	trav_req_t req_data1;
	logic req_stall1;
	logic raystore_we;
	rayID_t raystore_write_addr;
	ray_vec_t raystore_write_data;
	logic [MEM_ADDR_W-1:0] addr_cache_to_sdram;
	logic [TRANS_W-1:0] transSize;
	logic readReq;
	logic readValid_out;
	logic [31:0] readData;
	logic doneRead;
	logic result_valid;
	trav_result_t result_data;

	logic [31:0] node_mem [NODE_WORDS];
	logic [31:0] rng;
	logic issue_on;
	logic took0;
	logic took1;
	logic mem_req_seen;
	logic [MEM_ADDR_W-1:0] mem_addr_seen;
	int mem_phase;
	int mem_wait;
	int mem_word_i;
	int mem_addr;
	int err_cnt;
	int check_cnt;
	int pending;
	int timeout;

	raypipe raypipe_inst (.*);

	raypipe_checker check_inst (.*);

	bind raypipe raypipe_properties props_inst (
		.clk(clk), .reset(reset),
		.req_valid0(req_valid0), .req_data0(req_data0), .req_stall0(req_stall0),
		.req_valid1(req_valid1), .req_data1(req_data1), .req_stall1(req_stall1),
		.node_valid(node_valid), .node_data(node_data), .node_stall(node_stall),
		.ray_valid(ray_valid), .ray_data(ray_data), .ray_stall(ray_stall),
		.readReq(readReq), .readValid_out(readValid_out), .doneRead(doneRead)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	// hashed over the full address, two small signed halves
	function automatic logic [31:0] fill_word(input int addr);
		logic [31:0] h;
		h = (32'(addr) + 32'd1) * 32'h9E37_79B1;
		h = h ^ (h >> 13);
		return {{9{h[22]}}, h[22:16], {9{h[6]}}, h[6:0]};
	endfunction

	task automatic rand_coord(input int span, output coord_t c);
		logic [31:0] r;
		next_rand(r);
		c = coord_t'(int'(r % 32'(2 * span)) - span);
	endtask

	task automatic rand_ray(output ray_vec_t ray);
		logic [31:0] r;
		rand_coord(40, ray.origin.x);
		rand_coord(40, ray.origin.y);
		rand_coord(40, ray.origin.z);
		// up to about 2.3 either way, negative axes included
		rand_coord(600, ray.inv_dir.x);
		rand_coord(600, ray.inv_dir.y);
		rand_coord(600, ray.inv_dir.z);
		next_rand(r);
		ray.t_max = dist_t'(r % 32'd400);
	endtask

	task automatic drive_port(input logic took, inout logic valid, inout trav_req_t data);
		logic [31:0] r;
		if (took || !valid) begin
			next_rand(r);
			valid = issue_on && (r[1:0] != 2'b00);
			data.rayID = r[11:8];
			// mostly a hot set of 24 nodes so lines get reused and evicted
			if (r[3:2] == 2'b00) begin
				data.nodeID = r[23:16];
			end else begin
				data.nodeID = nodeID_t'(r[23:16] % 8'd24);
			end
		end
	endtask

	// memory answers after a random delay, three words then doneRead
	task automatic drive_memory();
		logic [31:0] r;
		readValid_out = 1'b0;
		doneRead = 1'b0;
		case (mem_phase)
			0: begin
				if (mem_req_seen) begin
					next_rand(r);
					mem_addr = int'(mem_addr_seen);
					mem_wait = int'(r % 32'd5);
					mem_word_i = 0;
					mem_phase = 1;
				end
			end
			1: begin
				if (mem_wait > 0) begin
					mem_wait--;
				end else begin
					mem_phase = 2;
				end
			end
			2: begin
				readValid_out = 1'b1;
				readData = node_mem[mem_addr + mem_word_i];
				mem_word_i++;
				if (mem_word_i == WORDS_PER_NODE) begin
					mem_phase = 3;
				end
			end
			default: begin
				doneRead = 1'b1;
				mem_phase = 0;
			end
		endcase
	endtask

	task automatic step(input logic write_seq, input int write_id);
		logic [31:0] r;
		@(negedge clk);
		took0 = req_valid0 && !req_stall0;
		took1 = req_valid1 && !req_stall1;
		mem_req_seen = readReq;
		mem_addr_seen = addr_cache_to_sdram;
		@(posedge clk);
		#DRIVE_DLY;
		drive_memory();
		drive_port(took0, req_valid0, req_data0);
		drive_port(took1, req_valid1, req_data1);
		next_rand(r);
		raystore_we = write_seq || (issue_on && (r[5:3] == 3'b000));
		raystore_write_addr = write_seq ? rayID_t'(write_id) : r[15:12];
		if (raystore_we) begin
			rand_ray(raystore_write_data);
		end
	endtask

	initial begin
		rng = 32'h6369_a0a6;
		reset = 1'b1;
		issue_on = 1'b0;
		req_valid0 = 1'b0;
		req_valid1 = 1'b0;
		req_data0 = '0;
		req_data1 = '0;
		raystore_we = 1'b0;
		raystore_write_addr = '0;
		raystore_write_data = '0;
		readValid_out = 1'b0;
		readData = '0;
		doneRead = 1'b0;
		mem_phase = 0;
		for (int i = 0; i < NODE_WORDS; i++) begin
			node_mem[i] = fill_word(i);
		end
		repeat (16) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b0;
		for (int i = 0; i < NUM_RAYS; i++) begin
			step(1'b1, i);
		end
		issue_on = 1'b1;
		repeat (TRAFFIC_CYCLES) step(1'b0, 0);
		issue_on = 1'b0;
		timeout = 0;
		while ((pending != 0 || req_valid0 || req_valid1) && timeout < DRAIN_TIMEOUT) begin
			step(1'b0, 0);
			timeout++;
		end
		if (timeout >= DRAIN_TIMEOUT) begin
			$display("timeout: requests still outstanding after the drain period");
		end
		$display("checks %0d errors %0d assertion failures %0d", check_cnt, err_cnt,
			raypipe_inst.props_inst.fail_cnt);
		if (err_cnt == 0 && timeout < DRAIN_TIMEOUT && raypipe_inst.props_inst.fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
rtl/raypipe_geom_pkg.sv
rtl/raypipe_mem_pkg.sv
rtl/arbitor.sv
rtl/cache_and_miss_handler.sv
rtl/raystore.sv
rtl/trav_unit.sv
rtl/raypipe.sv
verification/raypipe_properties.sv
verification/raypipe_checker.sv
verification/raypipe_tb.sv
